//--- run.sh
#!/bin/sh
verilator --binary --timing --assert --top-module tb_htif_bridge -f src.f \
  && ./obj_dir/Vtb_htif_bridge \
  || exit 1

//--- source/eth_rx.sv
`timescale 1ns/100ps

module eth_rx
  import host_pkg::*;
  import htif_pkg::*;
(
  input  logic     clk_offchip,
  input  logic     rst,
  input  logic     eth_in_val,
  input  word_t    eth_in_bits,
  output logic     eth_in_rdy,
  input  logic     credit_return,
  output logic     req_valid,
  output cmd_t     req_cmd,
  output seqno_t   req_seqno,
  output cr_data_t req_addr,
  output cr_data_t req_data,
  output logic     error_eth
);

  localparam int WCNT_W = $clog2(MAX_REQ_WORDS);
  localparam int CRED_W = $clog2(NUM_CREDITS + 1);

  typedef enum logic [1:0] {RX_WORDS, RX_HOLD, RX_ERROR} rx_state_t;

  rx_state_t         state;
  rx_state_t         next_state;
  logic [WCNT_W-1:0] wcnt;
  logic [CRED_W-1:0] credits;
  logic              need_data;
  logic              accept;
  logic              hdr_ok;
  logic              last_word;
  logic              spend;
  cmd_t              hdr_cmd;
  paysize_t          hdr_paysize;

  assign accept      = eth_in_val && eth_in_rdy;
  assign hdr_cmd     = eth_in_bits[15:0];
  assign hdr_paysize = eth_in_bits[63:32];

  // payload size must match the command
  always_comb
  begin
    case (hdr_cmd)
      CMD_READ_CR, CMD_WRITE_CR: hdr_ok = (hdr_paysize == CR_PAYSIZE);
      CMD_START, CMD_STOP:       hdr_ok = (hdr_paysize == '0);
      default:                   hdr_ok = 1'b0;
    endcase
  end

  // the address word ends the request unless a write data word follows
  assign last_word = (wcnt == WCNT_W'(MAX_REQ_WORDS - 1)) ||
                     (wcnt == WCNT_W'(1) && !need_data);

  // a complete request is released only against a held credit
  assign spend = ((state == RX_WORDS && accept && last_word) || state == RX_HOLD) &&
                 (credits != '0);

  always_comb
  begin
    next_state = state;
    case (state)
      RX_WORDS:
      begin
        if (accept && wcnt == '0 && !hdr_ok)
          next_state = RX_ERROR;
        else if (accept && last_word && credits == '0)
          next_state = RX_HOLD;
      end
      RX_HOLD:
      begin
        if (credits != '0)
          next_state = RX_WORDS;
      end
      default: next_state = RX_ERROR;
    endcase
  end

  always_ff @(posedge clk_offchip)
  begin
    if (rst)
    begin
      state      <= RX_WORDS;
      wcnt       <= '0;
      credits    <= CRED_W'(NUM_CREDITS);
      eth_in_rdy <= 1'b0;
      req_valid  <= 1'b0;
    end
    else
    begin
      state      <= next_state;
      eth_in_rdy <= (next_state == RX_WORDS);
      req_valid  <= spend;
      credits    <= credits + CRED_W'(credit_return) - CRED_W'(spend);
      if (accept)
        wcnt <= last_word ? '0 : wcnt + 1'b1;
    end
  end

  // request fields, picked by word position
  always_ff @(posedge clk_offchip)
  begin
    if (accept)
    begin
      if (wcnt == '0)
      begin
        req_cmd   <= hdr_cmd;
        req_seqno <= eth_in_bits[31:16];
        need_data <= (hdr_cmd == CMD_WRITE_CR);
        req_data  <= '0;
      end
      else if (wcnt == WCNT_W'(1))
        req_addr <= eth_in_bits[31:0];
      else
        req_data <= eth_in_bits[31:0];
    end
  end

  assign error_eth = (state == RX_ERROR);

endmodule

//--- source/eth_tx.sv
`timescale 1ns/100ps

module eth_tx
  import host_pkg::*;
  import htif_pkg::*;
(
  input  logic       clk_offchip,
  input  logic       rst,
  input  logic       resp_valid,
  input  seqno_t     resp_seqno,
  input  logic [7:0] resp_code,
  input  logic       resp_has_data,
  input  cr_data_t   resp_data,
  output logic       eth_out_val,
  output word_t      eth_out_bits,
  input  logic       eth_out_rdy,
  output logic       credit_return
);

  typedef enum logic [1:0] {TX_IDLE, TX_HDR, TX_DATA} tx_state_t;

  tx_state_t state;
  word_t     hdr_word;
  word_t     data_word;
  paysize_t  paysize;
  logic      has_data;
  logic      fire;

  assign paysize = resp_has_data ? CR_PAYSIZE : '0;
  assign fire    = eth_out_val && eth_out_rdy;

  // response code sits in the low byte of the command field
  always_ff @(posedge clk_offchip)
  begin
    if (resp_valid)
    begin
      hdr_word  <= {paysize, resp_seqno, 8'h00, resp_code};
      data_word <= word_t'(resp_data);
      has_data  <= resp_has_data;
    end
  end

  always_ff @(posedge clk_offchip)
  begin
    if (rst)
    begin
      state         <= TX_IDLE;
      credit_return <= 1'b0;
    end
    else
    begin
      credit_return <= 1'b0;
      case (state)
        TX_IDLE:
        begin
          if (resp_valid)
            state <= TX_HDR;
        end
        TX_HDR:
        begin
          if (fire && has_data)
            state <= TX_DATA;
          else if (fire)
          begin
            state         <= TX_IDLE;
            credit_return <= 1'b1;
          end
        end
        TX_DATA:
        begin
          // last word gone, receiver may release the next request
          if (fire)
          begin
            state         <= TX_IDLE;
            credit_return <= 1'b1;
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  assign eth_out_val  = (state != TX_IDLE);
  assign eth_out_bits = (state == TX_DATA) ? data_word : hdr_word;

endmodule

//--- source/host_pkg.sv
package host_pkg;

  // one word of the host packet stream
  typedef logic [63:0] word_t;

  // header fields, packed as {paysize, seqno, cmd} from bit 63 down
  typedef logic [15:0] cmd_t;
  typedef logic [15:0] seqno_t;
  typedef logic [31:0] paysize_t;

  // command codes kept by the bridge
  localparam cmd_t CMD_READ_CR  = 16'd2;
  localparam cmd_t CMD_WRITE_CR = 16'd3;
  localparam cmd_t CMD_START    = 16'd4;
  localparam cmd_t CMD_STOP     = 16'd5;

  // control register commands carry one 8-byte value
  localparam paysize_t CR_PAYSIZE = 32'd8;

  // header, address and optional write data
  localparam int MAX_REQ_WORDS = 3;

  // requests allowed between the receiver and the response path
  localparam int NUM_CREDITS = 1;

endpackage

//--- source/htif_bridge.sv
`timescale 1ns/100ps

module htif_bridge
  import host_pkg::*;
  import htif_pkg::*;
(
  input  logic    clk_offchip,
  input  logic    rst,
  input  logic    eth_in_val,
  input  word_t   eth_in_bits,
  output logic    eth_in_rdy,
  output logic    eth_out_val,
  output word_t   eth_out_bits,
  input  logic    eth_out_rdy,
  output logic    htif_in_val,
  output nibble_t htif_in_bits,
  input  logic    htif_in_rdy,
  output logic    htif_out_rdy,
  input  logic    htif_out_val,
  input  nibble_t htif_out_bits,
  output logic    error_eth,
  output logic    error_htif
);

  // request from the receiver to the link
  logic     req_valid;
  cmd_t     req_cmd;
  seqno_t   req_seqno;
  cr_data_t req_addr;
  cr_data_t req_data;

  // reply from the link to the transmitter
  logic       resp_valid;
  seqno_t     resp_seqno;
  logic [7:0] resp_code;
  logic       resp_has_data;
  cr_data_t   resp_data;

  logic credit_return;

  eth_rx i_eth_rx (
    .clk_offchip   (clk_offchip),
    .rst           (rst),
    .eth_in_val    (eth_in_val),
    .eth_in_bits   (eth_in_bits),
    .eth_in_rdy    (eth_in_rdy),
    .credit_return (credit_return),
    .req_valid     (req_valid),
    .req_cmd       (req_cmd),
    .req_seqno     (req_seqno),
    .req_addr      (req_addr),
    .req_data      (req_data),
    .error_eth     (error_eth)
  );

  htif_link i_htif_link (
    .clk_offchip   (clk_offchip),
    .rst           (rst),
    .req_valid     (req_valid),
    .req_cmd       (req_cmd),
    .req_seqno     (req_seqno),
    .req_addr      (req_addr),
    .req_data      (req_data),
    .htif_in_val   (htif_in_val),
    .htif_in_bits  (htif_in_bits),
    .htif_in_rdy   (htif_in_rdy),
    .htif_out_rdy  (htif_out_rdy),
    .htif_out_val  (htif_out_val),
    .htif_out_bits (htif_out_bits),
    .resp_valid    (resp_valid),
    .resp_seqno    (resp_seqno),
    .resp_code     (resp_code),
    .resp_has_data (resp_has_data),
    .resp_data     (resp_data),
    .error_htif    (error_htif)
  );

  eth_tx i_eth_tx (
    .clk_offchip   (clk_offchip),
    .rst           (rst),
    .resp_valid    (resp_valid),
    .resp_seqno    (resp_seqno),
    .resp_code     (resp_code),
    .resp_has_data (resp_has_data),
    .resp_data     (resp_data),
    .eth_out_val   (eth_out_val),
    .eth_out_bits  (eth_out_bits),
    .eth_out_rdy   (eth_out_rdy),
    .credit_return (credit_return)
  );

endmodule

//--- source/htif_link.sv
`timescale 1ns/100ps

module htif_link
  import host_pkg::*;
  import htif_pkg::*;
(
  input  logic       clk_offchip,
  input  logic       rst,
  input  logic       req_valid,
  input  cmd_t       req_cmd,
  input  seqno_t     req_seqno,
  input  cr_data_t   req_addr,
  input  cr_data_t   req_data,
  output logic       htif_in_val,
  output nibble_t    htif_in_bits,
  input  logic       htif_in_rdy,
  output logic       htif_out_rdy,
  input  logic       htif_out_val,
  input  nibble_t    htif_out_bits,
  output logic       resp_valid,
  output seqno_t     resp_seqno,
  output logic [7:0] resp_code,
  output logic       resp_has_data,
  output cr_data_t   resp_data,
  output logic       error_htif
);

  localparam int NIB_W   = $bits(nibble_t);
  localparam int CODE_W  = NIB_W * CMD_NIBBLES;
  localparam int TX_BITS = NIB_W * (CMD_NIBBLES + ADDR_NIBBLES + DATA_NIBBLES);
  localparam int RX_BITS = NIB_W * (CMD_NIBBLES + DATA_NIBBLES);

  typedef enum logic [1:0] {LK_IDLE, LK_SEND, LK_RECV, LK_ERROR} link_state_t;

  link_state_t        state;
  nib_count_t         nib_cnt;
  nib_count_t         send_cnt;
  nib_count_t         recv_cnt;
  logic [TX_BITS-1:0] tx_shift;
  logic [RX_BITS-1:0] reply;
  logic               send_fire;
  logic               recv_fire;
  logic               send_last;
  logic               recv_last;
  logic               load;

  assign load      = (state == LK_IDLE) && req_valid;
  assign send_fire = htif_in_val && htif_in_rdy;
  assign recv_fire = htif_out_val && htif_out_rdy;
  assign send_last = (nib_cnt == send_cnt - 1'b1);
  assign recv_last = (nib_cnt == recv_cnt - 1'b1);

  always_ff @(posedge clk_offchip)
  begin
    if (rst)
    begin
      state      <= LK_IDLE;
      nib_cnt    <= '0;
      resp_valid <= 1'b0;
    end
    else
    begin
      resp_valid <= 1'b0;
      case (state)
        LK_IDLE:
        begin
          nib_cnt <= '0;
          if (req_valid)
            state <= LK_SEND;
        end
        LK_SEND:
        begin
          // target must stay quiet until the request is out
          if (htif_out_val)
            state <= LK_ERROR;
          else if (send_fire && send_last)
          begin
            state   <= LK_RECV;
            nib_cnt <= '0;
          end
          else if (send_fire)
            nib_cnt <= nib_cnt + 1'b1;
        end
        LK_RECV:
        begin
          if (recv_fire && recv_last)
          begin
            state      <= LK_IDLE;
            resp_valid <= 1'b1;
          end
          else if (recv_fire)
            nib_cnt <= nib_cnt + 1'b1;
        end
        default: state <= LK_ERROR;
      endcase
    end
  end

  // command byte, address, then write data, low nibble first
  always_ff @(posedge clk_offchip)
  begin
    if (load)
    begin
      tx_shift      <= {req_data, req_addr, req_cmd[CODE_W-1:0]};
      reply         <= '0;
      resp_seqno    <= req_seqno;
      resp_has_data <= (req_cmd == CMD_READ_CR);
      send_cnt      <= (req_cmd == CMD_WRITE_CR) ?
                       nib_count_t'(CMD_NIBBLES + ADDR_NIBBLES + DATA_NIBBLES) :
                       nib_count_t'(CMD_NIBBLES + ADDR_NIBBLES);
      recv_cnt      <= (req_cmd == CMD_READ_CR) ?
                       nib_count_t'(CMD_NIBBLES + DATA_NIBBLES) :
                       nib_count_t'(CMD_NIBBLES);
    end
    else
    begin
      if (send_fire)
        tx_shift <= tx_shift >> NIB_W;
      // reply nibbles land at their own position
      if (recv_fire)
        reply[nib_cnt * NIB_W +: NIB_W] <= htif_out_bits;
    end
  end

  assign htif_in_val  = (state == LK_SEND);
  assign htif_in_bits = tx_shift[NIB_W-1:0];
  assign htif_out_rdy = (state == LK_RECV);
  assign resp_code    = reply[CODE_W-1:0];
  assign resp_data    = reply[RX_BITS-1:CODE_W];
  assign error_htif   = (state == LK_ERROR);

endmodule

//--- source/htif_pkg.sv
package htif_pkg;

  // one symbol on the target link
  typedef logic [3:0] nibble_t;

  // control register value as seen by the target
  typedef logic [31:0] cr_data_t;

  // counts nibbles of one request or reply, up to 18
  typedef logic [4:0] nib_count_t;

  // nibbles per field, sent least significant first
  localparam int CMD_NIBBLES  = 2;
  localparam int ADDR_NIBBLES = 8;
  localparam int DATA_NIBBLES = 8;

endpackage

//--- src.f
source/host_pkg.sv
source/htif_pkg.sv
source/eth_rx.sv
source/htif_link.sv
source/eth_tx.sv
source/htif_bridge.sv
test/htif_bridge_asserts.sv
test/tb_htif_bridge.sv

//--- test/htif_bridge_asserts.sv
`timescale 1ns/100ps

module htif_bridge_asserts
  import host_pkg::*;
  import htif_pkg::*;
(
  input logic    clk_offchip,
  input logic    rst,
  input logic    eth_in_val,
  input word_t   eth_in_bits,
  input logic    eth_in_rdy,
  input logic    eth_out_val,
  input word_t   eth_out_bits,
  input logic    eth_out_rdy,
  input logic    htif_in_val,
  input nibble_t htif_in_bits,
  input logic    htif_in_rdy,
  input logic    htif_out_rdy,
  input logic    htif_out_val,
  input logic    error_eth,
  input logic    error_htif
);

  int fail_cnt = 0;

  // captured requests as {seqno, cmd, addr, data}
  logic [95:0] req_mem [2];
  logic [95:0] act;
  logic        wr_ptr;
  logic        rd_ptr;
  logic [1:0]  in_wcnt;
  cmd_t        cap_cmd;
  seqno_t      cap_seqno;
  cr_data_t    cap_addr;
  cr_data_t    last_wdata;
  logic [4:0]  snd_idx;
  logic [3:0]  rcv_idx;
  logic        out_idx;
  logic [1:0]  outstanding;
  logic        bad_seen;
  logic        rdy_exp;
  logic        in_fire;
  logic        snd_fire;
  logic        rcv_fire;
  logic        out_fire;
  logic        hdr_legal;
  logic        req_done;
  logic        resp_done;
  logic        snd_last;
  logic        rcv_last;
  cmd_t        snd_cmd;
  logic [71:0] snd_stream;
  nibble_t     exp_nib;
  word_t       exp_hdr;

  assign in_fire    = eth_in_val && eth_in_rdy;
  assign snd_fire   = htif_in_val && htif_in_rdy;
  assign rcv_fire   = htif_out_val && htif_out_rdy;
  assign out_fire   = eth_out_val && eth_out_rdy;
  assign req_done   = in_fire && (in_wcnt == 2'd2 || (in_wcnt == 2'd1 && cap_cmd != CMD_WRITE_CR));
  assign resp_done  = out_fire && (out_idx || act[79:64] != CMD_READ_CR);
  assign snd_cmd    = req_mem[rd_ptr][79:64];
  // command byte first, then address, then write data
  assign snd_stream = {req_mem[rd_ptr][31:0], req_mem[rd_ptr][63:32], snd_cmd[7:0]};
  assign exp_nib    = snd_stream[{snd_idx, 2'b00} +: 4];
  assign snd_last   = snd_idx == ((snd_cmd == CMD_WRITE_CR) ? 5'd17 : 5'd9);
  // two code nibbles, plus eight data nibbles for a read
  assign rcv_last   = rcv_idx == ((act[79:64] == CMD_READ_CR) ? 4'd9 : 4'd1);
  // target answers with the command plus 8
  assign exp_hdr    = {(act[79:64] == CMD_READ_CR) ? CR_PAYSIZE : 32'd0,
                       act[95:80], 8'h00, act[71:64] + 8'd8};

  always_comb
  begin
    case (eth_in_bits[15:0])
      CMD_READ_CR, CMD_WRITE_CR: hdr_legal = (eth_in_bits[63:32] == CR_PAYSIZE);
      CMD_START, CMD_STOP:       hdr_legal = (eth_in_bits[63:32] == 32'd0);
      default:                   hdr_legal = 1'b0;
    endcase
  end

  always_ff @(posedge clk_offchip)
  begin
    if (rst)
    begin
      in_wcnt     <= 2'd0;
      wr_ptr      <= 1'b0;
      rd_ptr      <= 1'b0;
      snd_idx     <= 5'd0;
      rcv_idx     <= 4'd0;
      out_idx     <= 1'b0;
      outstanding <= 2'd0;
      bad_seen    <= 1'b0;
      rdy_exp     <= 1'b0;
      last_wdata  <= '0;
    end
    else
    begin
      outstanding <= outstanding + {1'b0, req_done} - {1'b0, resp_done};
      if (in_fire)
      begin
        case (in_wcnt)
          2'd0:
          begin
            cap_cmd   <= eth_in_bits[15:0];
            cap_seqno <= eth_in_bits[31:16];
            bad_seen  <= bad_seen || !hdr_legal;
            in_wcnt   <= 2'd1;
          end
          2'd1:
          begin
            cap_addr <= eth_in_bits[31:0];
            if (cap_cmd == CMD_WRITE_CR)
              in_wcnt <= 2'd2;
            else
            begin
              req_mem[wr_ptr] <= {cap_seqno, cap_cmd, eth_in_bits[31:0], 32'd0};
              wr_ptr          <= !wr_ptr;
              in_wcnt         <= 2'd0;
            end
          end
          default:
          begin
            req_mem[wr_ptr] <= {cap_seqno, cap_cmd, cap_addr, eth_in_bits[31:0]};
            wr_ptr          <= !wr_ptr;
            in_wcnt         <= 2'd0;
          end
        endcase
      end
      if (snd_fire && snd_last)
      begin
        snd_idx <= 5'd0;
        act     <= req_mem[rd_ptr];
        rd_ptr  <= !rd_ptr;
        rdy_exp <= 1'b1;
        if (snd_cmd == CMD_WRITE_CR)
          last_wdata <= req_mem[rd_ptr][31:0];
      end
      else if (snd_fire)
        snd_idx <= snd_idx + 5'd1;
      // link listens from the last request nibble to the last reply nibble
      if (rcv_fire && rcv_last)
      begin
        rcv_idx <= 4'd0;
        rdy_exp <= 1'b0;
      end
      else if (rcv_fire)
        rcv_idx <= rcv_idx + 4'd1;
      if (out_fire)
        out_idx <= !resp_done;
    end
  end

  a_nibble: assert property (@(posedge clk_offchip) disable iff (rst)
    snd_fire |-> htif_in_bits == exp_nib)
  else
  begin
    fail_cnt++;
    $error("[ERROR] htif_in_bits expected %h got %h", exp_nib, htif_in_bits);
  end

  a_out_rdy: assert property (@(posedge clk_offchip) disable iff (rst)
    htif_out_rdy == rdy_exp)
  else
  begin
    fail_cnt++;
    $error("[ERROR] htif_out_rdy expected %h got %h", rdy_exp, htif_out_rdy);
  end

  a_hdr: assert property (@(posedge clk_offchip) disable iff (rst)
    out_fire && !out_idx |-> eth_out_bits == exp_hdr)
  else
  begin
    fail_cnt++;
    $error("[ERROR] eth_out_bits expected %h got %h", exp_hdr, eth_out_bits);
  end

  a_data: assert property (@(posedge clk_offchip) disable iff (rst)
    out_fire && out_idx |-> eth_out_bits == {32'd0, last_wdata})
  else
  begin
    fail_cnt++;
    $error("[ERROR] eth_out_bits expected %h got %h",
           {32'd0, last_wdata}, eth_out_bits);
  end

  a_in_hold: assert property (@(posedge clk_offchip) disable iff (rst)
    htif_in_val && !htif_in_rdy |=> htif_in_val && $stable(htif_in_bits))
  else
  begin
    fail_cnt++;
    $error("htif_in nibble dropped or changed while the target stalled");
  end

  a_out_hold: assert property (@(posedge clk_offchip) disable iff (rst)
    eth_out_val && !eth_out_rdy |=> eth_out_val && $stable(eth_out_bits))
  else
  begin
    fail_cnt++;
    $error("eth_out word dropped or changed while the host stalled");
  end

  a_credit: assert property (@(posedge clk_offchip) disable iff (rst)
    outstanding == 2'd2 |-> !eth_in_rdy)
  else
  begin
    fail_cnt++;
    $error("eth_in_rdy high while a second request is waiting");
  end

  a_bad_hdr: assert property (@(posedge clk_offchip) disable iff (rst)
    in_fire && in_wcnt == 2'd0 && !hdr_legal |=> error_eth)
  else
  begin
    fail_cnt++;
    $error("illegal header did not raise error_eth");
  end

  a_err_rdy: assert property (@(posedge clk_offchip) disable iff (rst)
    error_eth |-> !eth_in_rdy)
  else
  begin
    fail_cnt++;
    $error("eth_in_rdy high in the error state");
  end

  a_no_err: assert property (@(posedge clk_offchip) disable iff (rst)
    !bad_seen |-> !error_eth && !error_htif)
  else
  begin
    fail_cnt++;
    $error("error flag raised without a bad header");
  end

endmodule

bind htif_bridge htif_bridge_asserts i_asserts (.*);

//--- test/tb_htif_bridge.sv
`timescale 1ns/100ps

module tb_htif_bridge
  import host_pkg::*;
  import htif_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 2000;

  logic    clk_offchip   = 1'b0;
  logic    rst           = 1'b1;
  logic    eth_in_val    = 1'b0;
  word_t   eth_in_bits   = '0;
  logic    eth_out_rdy   = 1'b0;
  logic    htif_in_rdy   = 1'b0;
  logic    htif_out_val  = 1'b0;
  nibble_t htif_out_bits = '0;
  logic    eth_in_rdy;
  logic    eth_out_val;
  word_t   eth_out_bits;
  logic    htif_in_val;
  nibble_t htif_in_bits;
  logic    htif_out_rdy;
  logic    error_eth;
  logic    error_htif;

  integer      seed = 9263;
  int          cycles = 0;
  int          out_words = 0;
  // target side state
  logic [71:0] tgt_req;
  int          tgt_cnt = 0;
  logic [7:0]  tgt_code;
  cr_data_t    tgt_wdata = '0;
  nibble_t     reply_q[$];

  htif_bridge i_htif_bridge (
    .clk_offchip   (clk_offchip),
    .rst           (rst),
    .eth_in_val    (eth_in_val),
    .eth_in_bits   (eth_in_bits),
    .eth_in_rdy    (eth_in_rdy),
    .eth_out_val   (eth_out_val),
    .eth_out_bits  (eth_out_bits),
    .eth_out_rdy   (eth_out_rdy),
    .htif_in_val   (htif_in_val),
    .htif_in_bits  (htif_in_bits),
    .htif_in_rdy   (htif_in_rdy),
    .htif_out_rdy  (htif_out_rdy),
    .htif_out_val  (htif_out_val),
    .htif_out_bits (htif_out_bits),
    .error_eth     (error_eth),
    .error_htif    (error_htif)
  );

  initial
  begin
    forever #10 clk_offchip = !clk_offchip;
  end

  // target model and random back-pressure
  always @(posedge clk_offchip)
  begin
    if (eth_out_val && eth_out_rdy)
      out_words++;
    if (htif_out_val && htif_out_rdy)
      void'(reply_q.pop_front());
    if (htif_in_val && htif_in_rdy)
    begin
      tgt_req[tgt_cnt*4 +: 4] = htif_in_bits;
      tgt_cnt++;
      if (tgt_cnt == 18 || (tgt_cnt == 10 && tgt_req[7:0] != CMD_WRITE_CR[7:0]))
      begin
        tgt_code = tgt_req[7:0] + 8'd8;
        reply_q.push_back(tgt_code[3:0]);
        reply_q.push_back(tgt_code[7:4]);
        if (tgt_req[7:0] == CMD_READ_CR[7:0])
        begin
          for (int i = 0; i < 8; i++)
            reply_q.push_back(tgt_wdata[i*4 +: 4]);
        end
        if (tgt_req[7:0] == CMD_WRITE_CR[7:0])
          tgt_wdata = tgt_req[71:40];
        tgt_cnt = 0;
      end
    end
    #2;
    htif_in_rdy   = ($random(seed) & 3) != 0;
    eth_out_rdy   = ($random(seed) & 3) != 0;
    htif_out_val  = reply_q.size() != 0;
    htif_out_bits = (reply_q.size() != 0) ? reply_q[0] : 4'h0;
  end

  always @(posedge clk_offchip)
  begin
    if (i_htif_bridge.i_asserts.fail_cnt != 0)
    begin
      $display("Errors found");
      $fatal(1, "assertion check failed");
    end
  end

  always @(posedge clk_offchip)
  begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("Errors found");
      $fatal(1, "run did not finish within %0d cycles", TIMEOUT_CYCLES);
    end
  end

  task automatic send_word(input word_t w);
    eth_in_val  = 1'b1;
    eth_in_bits = w;
    @(posedge clk_offchip);
    while (!eth_in_rdy)
      @(posedge clk_offchip);
    #2;
    eth_in_val = 1'b0;
  endtask

  task automatic send_request(input cmd_t cmd, input seqno_t seqno,
                              input cr_data_t addr, input cr_data_t data);
    paysize_t size;
    size = (cmd == CMD_READ_CR || cmd == CMD_WRITE_CR) ? CR_PAYSIZE : 32'd0;
    send_word({size, seqno, cmd});
    send_word({32'd0, addr});
    if (cmd == CMD_WRITE_CR)
      send_word({32'd0, data});
  endtask

  // returns just after an edge so the next drive is clear of it
  task automatic wait_words(input int n);
    while (out_words < n)
    begin
      @(posedge clk_offchip);
      #2;
    end
  endtask

  initial
  begin
    repeat (4) @(posedge clk_offchip);
    #2;
    rst = 1'b0;
    send_request(CMD_WRITE_CR, 16'h0001, 32'h0000_0010, 32'hCAFE_1234);
    wait_words(1);
    send_request(CMD_START, 16'h0002, 32'h0000_0000, 32'h0);
    wait_words(2);
    send_request(CMD_READ_CR, 16'h0003, 32'h0000_0010, 32'h0);
    wait_words(4);
    send_request(CMD_STOP, 16'h0004, 32'h0000_0000, 32'h0);
    wait_words(5);
    // second request goes in while the first is still in flight
    send_request(CMD_WRITE_CR, 16'h0005, 32'h0000_0020, 32'h5A5A_0F0F);
    send_request(CMD_READ_CR, 16'h0006, 32'h0000_0020, 32'h0);
    wait_words(8);
    send_word({32'd0, 16'h0007, 16'h0007});
    while (!error_eth)
      @(posedge clk_offchip);
    repeat (4) @(posedge clk_offchip);
    if (i_htif_bridge.i_asserts.fail_cnt != 0)
    begin
      $display("Errors found");
      $fatal(1, "assertion check failed");
    end
    else
    begin
      $display("No errors");
      $finish;
    end
  end

endmodule
